// File: rf_pkg.sv
////////////////////////////////////////
// Register file widths, integrity code
// masks and the protected word type
////////////////////////////////////////

package rf_pkg;

  // Word layout
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IntgWidth = 7;
  localparam int unsigned WordWidth = DataWidth + IntgWidth;

  // Covers 32 registers, top bit unused with 16
  localparam int unsigned AddrWidth = 5;

  ////////////////////////////////////////
  // Integrity code
  ////////////////////////////////////////

  // Check bit k covers data bits whose index mod 7 is k
  localparam logic [IntgWidth-1:0][DataWidth-1:0] IntgMask = {
    32'h0810_2040,  // bits 6, 13, 20, 27
    32'h0408_1020,
    32'h0204_0810,
    32'h8102_0408,
    32'h4081_0204,
    32'h2040_8102,
    32'h1020_4081   // bits 0, 7, 14, 21, 28
  };

  ////////////////////////////////////////
  // Protected word
  ////////////////////////////////////////

  typedef struct packed {
    logic [IntgWidth-1:0] intg;
    logic [DataWidth-1:0] data;
  } rf_fields_t;

  // Raw view for storage, field view for checking and ports
  typedef union packed {
    logic [WordWidth-1:0] raw;
    rf_fields_t           part;
  } rf_word_t;

endpackage

// File: rf_port_if.sv
////////////////////////////////////////
// Register file port between control
// and storage
////////////////////////////////////////

`timescale 1ns/100ps

interface rf_port_if;

  // Write side
  logic                         we;
  logic [rf_pkg::AddrWidth-1:0] waddr;
  rf_pkg::rf_word_t             wdata;

  // Read side
  logic [rf_pkg::AddrWidth-1:0] raddr;
  rf_pkg::rf_word_t             rdata;

  modport ctrl (
    output we,
    output waddr,
    output wdata,
    output raddr,
    input  rdata
  );

  modport regs (
    input  we,
    input  waddr,
    input  wdata,
    input  raddr,
    output rdata
  );

endinterface

// File: rf_intg_check.sv
////////////////////////////////////////
// Integrity check of a read word
////////////////////////////////////////

`timescale 1ns/100ps

module rf_intg_check (
  input  rf_pkg::rf_word_t word_i,
  output logic             err_o
);

  logic [rf_pkg::IntgWidth-1:0] intg_calc;

  // Each check bit is the parity of its masked data bits
  always_comb begin
    for (int k = 0; k < rf_pkg::IntgWidth; k++) begin
      intg_calc[k] = ^(word_i.part.data & rf_pkg::IntgMask[k]);
    end
  end

  // Any flipped bit in data or code shows up here
  assign err_o = (intg_calc != word_i.part.intg);

endmodule

// File: rf_regs.sv
////////////////////////////////////////
// Flop-based register storage
// One write port, one read port, x0 zero
////////////////////////////////////////

`timescale 1ns/100ps

module rf_regs #(
  parameter int unsigned NumRegs = 32
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  rf_port_if.regs rf
);

  // x0 has no storage
  rf_pkg::rf_word_t regs_q [1:NumRegs-1];
  logic [NumRegs-1:1] we_dec;

  ////////////////////////////////////////
  // Write
  ////////////////////////////////////////

  for (genvar i = 1; i < NumRegs; i++) begin : gen_regs
    assign we_dec[i] = rf.we & (rf.waddr == rf_pkg::AddrWidth'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs_q[i].raw <= '0;
      end else if (we_dec[i]) begin
        regs_q[i] <= rf.wdata;
      end
    end
  end

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  // All-zero word is a valid code, so x0 reads clean
  always_comb begin
    rf.rdata.raw = '0;
    if ((rf.raddr != '0) && (rf.raddr < NumRegs)) begin
      rf.rdata = regs_q[rf.raddr];
    end
  end

endmodule

// File: rf_ctrl.sv
////////////////////////////////////////
// Access control for the register file
// Grant, response, sleep and sticky alert
////////////////////////////////////////

`timescale 1ns/100ps

module rf_ctrl #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  input  logic                         acc_req_i,
  input  logic                         acc_we_i,
  input  logic [rf_pkg::AddrWidth-1:0] acc_addr_i,
  input  logic [rf_pkg::DataWidth-1:0] acc_wdata_i,
  input  logic [rf_pkg::IntgWidth-1:0] acc_wintg_i,
  output logic                         acc_gnt_o,
  output logic                         acc_rvalid_o,
  output logic [rf_pkg::DataWidth-1:0] acc_rdata_o,
  output logic                         acc_err_o,

  output logic                         core_sleep_o,
  output logic                         alert_major_o,

  rf_port_if.ctrl                      rf,
  input  logic                         intg_err_i
);

  logic [rf_pkg::AddrWidth-1:0] addr_eff;
  logic [rf_pkg::AddrWidth-1:0] raddr_q;
  logic                         gnt;
  logic                         rvalid_q;
  logic                         is_read_q;
  logic                         alert_q;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Nonexistent registers fold onto x0
  assign addr_eff = (acc_addr_i < NumRegs) ? acc_addr_i : '0;

  // One response slot, so no grant while it is busy
  assign gnt       = acc_req_i & ~rvalid_q;
  assign acc_gnt_o = gnt;

  assign rf.we             = gnt & acc_we_i;
  assign rf.waddr          = addr_eff;
  assign rf.wdata.part.intg = acc_wintg_i;
  assign rf.wdata.part.data = acc_wdata_i;
  assign rf.raddr          = raddr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q  <= 1'b0;
      is_read_q <= 1'b0;
      raddr_q   <= '0;
    end else begin
      rvalid_q  <= gnt;
      is_read_q <= gnt & ~acc_we_i;
      if (gnt) begin
        raddr_q <= addr_eff;
      end
    end
  end

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  assign acc_rvalid_o = rvalid_q;
  // Writes answer with zero data
  assign acc_rdata_o  = is_read_q ? rf.rdata.part.data : '0;
  assign acc_err_o    = is_read_q & intg_err_i;

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | acc_err_o;
    end
  end

  assign alert_major_o = alert_q;
  assign core_sleep_o  = ~acc_req_i & ~rvalid_q;

endmodule

// File: rf_top.sv
////////////////////////////////////////
// Protected register file top level
// Control, storage and integrity check
////////////////////////////////////////

`timescale 1ns/100ps

module rf_top #(
  parameter int unsigned NumRegs = 32
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Access port
  input  logic                         acc_req_i,
  output logic                         acc_gnt_o,
  input  logic                         acc_we_i,
  input  logic [rf_pkg::AddrWidth-1:0] acc_addr_i,
  input  logic [rf_pkg::DataWidth-1:0] acc_wdata_i,
  input  logic [rf_pkg::IntgWidth-1:0] acc_wintg_i,
  output logic                         acc_rvalid_o,
  output logic [rf_pkg::DataWidth-1:0] acc_rdata_o,
  output logic                         acc_err_o,

  // Status
  output logic                         core_sleep_o,
  output logic                         alert_major_o
);

  logic intg_err;

  rf_port_if rf_bus ();

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  rf_ctrl #(
    .NumRegs(NumRegs)
  ) u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acc_req_i    (acc_req_i),
    .acc_we_i     (acc_we_i),
    .acc_addr_i   (acc_addr_i),
    .acc_wdata_i  (acc_wdata_i),
    .acc_wintg_i  (acc_wintg_i),
    .acc_gnt_o    (acc_gnt_o),
    .acc_rvalid_o (acc_rvalid_o),
    .acc_rdata_o  (acc_rdata_o),
    .acc_err_o    (acc_err_o),
    .core_sleep_o (core_sleep_o),
    .alert_major_o(alert_major_o),
    .rf           (rf_bus.ctrl),
    .intg_err_i   (intg_err)
  );

  ////////////////////////////////////////
  // Storage and check
  ////////////////////////////////////////

  rf_regs #(
    .NumRegs(NumRegs)
  ) u_regs (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .rf    (rf_bus.regs)
  );

  // Checks the word as stored, before data and code are split
  rf_intg_check u_intg_check (
    .word_i(rf_bus.rdata),
    .err_o (intg_err)
  );

endmodule

// File: rf_assertions.sv
////////////////////////////////////////
// Concurrent checks on handshake, sleep
// and alert, bound to the top level
////////////////////////////////////////

`timescale 1ns/100ps

module rf_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic acc_req_i,
  input logic acc_gnt_o,
  input logic acc_rvalid_o,
  input logic core_sleep_o,
  input logic alert_major_o
);

  // Number of failed properties
  int unsigned fail_count = 0;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_gnt_o |-> acc_req_i)
    else begin
      fail_count++;
      $error("Grant seen without a request");
    end

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_gnt_o |=> acc_rvalid_o)
    else begin
      fail_count++;
      $error("No response in the cycle after a grant");
    end

  rvalid_only_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_rvalid_o |-> $past(acc_gnt_o))
    else begin
      fail_count++;
      $error("Response without a grant one cycle before");
    end

  ////////////////////////////////////////
  // Sleep and alert
  ////////////////////////////////////////

  no_sleep_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core_sleep_o && acc_rvalid_o))
    else begin
      fail_count++;
      $error("Sleep reported while a response is out");
    end

  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_major_o |=> alert_major_o)
    else begin
      fail_count++;
      $error("Major alert dropped before reset");
    end

endmodule

bind rf_top rf_assertions u_rf_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .acc_req_i    (acc_req_i),
  .acc_gnt_o    (acc_gnt_o),
  .acc_rvalid_o (acc_rvalid_o),
  .core_sleep_o (core_sleep_o),
  .alert_major_o(alert_major_o)
);

// File: tb_clk_gen.sv
////////////////////////////////////////
// Testbench clock and reset generator
////////////////////////////////////////

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // Released on an edge, flops still see reset there
    rst_no <= 1'b1;
  end

  always #(PeriodNs / 2) clk_o = ~clk_o;

endmodule

// File: tb_rf_top.sv
////////////////////////////////////////
// Testbench top for the register file
// Reads access lines, drives and checks
////////////////////////////////////////

`timescale 1ns/100ps

module tb_rf_top;

  localparam int unsigned MaxLines = 64;
  localparam int unsigned Cols     = 6;
  localparam logic [31:0] OpWrite  = 32'h1;
  localparam logic [31:0] OpRead   = 32'h2;

  logic                         clk;
  logic                         rst_n;
  logic                         acc_req;
  logic                         acc_we;
  logic [rf_pkg::AddrWidth-1:0] acc_addr;
  logic [rf_pkg::DataWidth-1:0] acc_wdata;
  logic [rf_pkg::IntgWidth-1:0] acc_wintg;
  logic                         acc_gnt;
  logic                         acc_rvalid;
  logic [rf_pkg::DataWidth-1:0] acc_rdata;
  logic                         acc_err;
  logic                         core_sleep;
  logic                         alert_major;

  // Six hex fields per access line
  logic [31:0] stim_mem [0:MaxLines*Cols-1];
  int unsigned num_lines;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;
  logic        alert_exp;

  tb_clk_gen #(
    .PeriodNs   (20),
    .ResetCycles(8)
  ) i_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  rf_top #(
    .NumRegs(32)
  ) i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .acc_req_i    (acc_req),
    .acc_gnt_o    (acc_gnt),
    .acc_we_i     (acc_we),
    .acc_addr_i   (acc_addr),
    .acc_wdata_i  (acc_wdata),
    .acc_wintg_i  (acc_wintg),
    .acc_rvalid_o (acc_rvalid),
    .acc_rdata_o  (acc_rdata),
    .acc_err_o    (acc_err),
    .core_sleep_o (core_sleep),
    .alert_major_o(alert_major)
  );

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] time %0t: %s got %h, expected %h", $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  // One cycle with req low
  task automatic idle_cycle();
    @(posedge clk);
    @(negedge clk);
    check_value("core_sleep_o", core_sleep, 1);
    check_value("acc_gnt_o", acc_gnt, 0);
    check_value("acc_rvalid_o", acc_rvalid, 0);
    check_value("acc_err_o", acc_err, 0);
    check_value("alert_major_o", alert_major, alert_exp);
  endtask

  task automatic run_access(input int unsigned line);
    logic [31:0] op;
    logic [31:0] exp_data;
    logic [31:0] exp_err;
    op       = stim_mem[line*Cols];
    exp_data = stim_mem[line*Cols+4];
    exp_err  = stim_mem[line*Cols+5];
    @(posedge clk);
    acc_req   <= 1'b1;
    acc_we    <= (op == OpWrite);
    acc_addr  <= stim_mem[line*Cols+1][rf_pkg::AddrWidth-1:0];
    acc_wdata <= stim_mem[line*Cols+2];
    acc_wintg <= stim_mem[line*Cols+3][rf_pkg::IntgWidth-1:0];
    @(negedge clk);
    check_value("core_sleep_o", core_sleep, 0);
    check_value("alert_major_o", alert_major, alert_exp);
    while (acc_gnt !== 1'b1) begin
      @(negedge clk);
      check_value("core_sleep_o", core_sleep, 0);
      check_value("alert_major_o", alert_major, alert_exp);
    end
    @(posedge clk);
    acc_req <= 1'b0;
    // Response is due exactly one cycle after gnt
    @(negedge clk);
    check_value("acc_rvalid_o", acc_rvalid, 1);
    check_value("acc_rdata_o", acc_rdata, exp_data);
    check_value("acc_err_o", acc_err, exp_err);
    check_value("core_sleep_o", core_sleep, 0);
    check_value("alert_major_o", alert_major, alert_exp);
    if (exp_err[0]) begin
      alert_exp = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int unsigned gap;
    void'($urandom(32'h74ba));
    acc_req       = 1'b0;
    acc_we        = 1'b0;
    acc_addr      = '0;
    acc_wdata     = '0;
    acc_wintg     = '0;
    alert_exp     = 1'b0;
    cycle_cnt     = 0;
    $readmemh("rf_stim.txt", stim_mem);
    num_lines = 0;
    while ((num_lines < MaxLines) && ((stim_mem[num_lines*Cols] == OpWrite) ||
                                      (stim_mem[num_lines*Cols] == OpRead))) begin
      num_lines++;
    end
    cycle_limit = 8 * num_lines + 100;
    @(posedge rst_n);
    idle_cycle();
    for (int unsigned i = 0; i < num_lines; i++) begin
      gap = $urandom % 4;
      repeat (gap) idle_cycle();
      run_access(i);
    end
    idle_cycle();
    if (num_lines == 0) begin
      $display("The stimulus file held no access lines");
      stop_with_failure();
    end else if (i_dut.u_rf_assertions.fail_count != 0) begin
      $display("A bound assertion on the DUT failed");
      stop_with_failure();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

  // Bound property failures end the run too
  always @(negedge clk) begin
    if (i_dut.u_rf_assertions.fail_count != 0) begin
      $display("A bound assertion on the DUT failed");
      stop_with_failure();
    end
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_with_failure();
    end
  end

endmodule

// File: rf_stim.txt
// op addr wdata wintg exp_rdata exp_err, all hex
// op 1 is a write, op 2 is a read; read lines carry zero wdata and wintg
1 01 00000001 01 00000000 0
1 02 000000FF 7E 00000000 0
1 03 FFFFFFFF 0F 00000000 0
1 05 80000000 08 00000000 0
1 08 12345678 15 00000000 0
1 0F 0000FFFF 03 00000000 0
1 10 FFFF0000 0C 00000000 0
1 1F A5A5A5A5 5F 00000000 0
// Read back
2 01 00000000 00 00000001 0
2 02 00000000 00 000000FF 0
2 03 00000000 00 FFFFFFFF 0
2 05 00000000 00 80000000 0
2 08 00000000 00 12345678 0
2 0F 00000000 00 0000FFFF 0
2 10 00000000 00 FFFF0000 0
2 1F 00000000 00 A5A5A5A5 0
// Never written, still reset value
2 04 00000000 00 00000000 0
// Register 0 ignores writes
1 00 FFFFFFFF 0F 00000000 0
2 00 00000000 00 00000000 0
// Read right after write
1 07 55555555 05 00000000 0
2 07 00000000 00 55555555 0
1 07 AAAAAAAA 0A 00000000 0
2 07 00000000 00 AAAAAAAA 0
1 01 00000100 02 00000000 0
2 01 00000000 00 00000100 0
// Broken code, stored as given
1 0A 12345678 14 00000000 0
2 0A 00000000 00 12345678 1
2 0A 00000000 00 12345678 1
2 03 00000000 00 FFFFFFFF 0
// Overwrite with a clean word
1 0A 00000000 00 00000000 0
2 0A 00000000 00 00000000 0

// File: src.f
rf_pkg.sv
rf_port_if.sv
rf_intg_check.sv
rf_regs.sv
rf_ctrl.sv
rf_top.sv
rf_assertions.sv
tb_clk_gen.sv
tb_rf_top.sv
